// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  localparam int BANK_WIDTH     = 32;
  localparam int BEN_WIDTH      = 4;
  localparam int SET_WIDTH      = 8;
  localparam int BANK_IDX_WIDTH = 5;   // room for up to 32 banks per line
  localparam int SET_COUNT      = 256;

  typedef logic [BANK_WIDTH-1:0]     bank_word_t;
  typedef logic [BEN_WIDTH-1:0]      ben_t;
  typedef logic [SET_WIDTH-1:0]      set_idx_t;
  typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;

  // full word store
  localparam ben_t BEN_ALL = 4'b1111;

endpackage

`default_nettype wire

// ==== dcache_wr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface dcache_wr_if #(
  parameter int NUM_BANKS = 8
);

  logic                  rd;
  logic                  wr;
  dcache_pkg::set_idx_t  set;
  logic [NUM_BANKS-1:0]  bank_en;
  dcache_pkg::bank_idx_t begin_bank;
  dcache_pkg::bank_idx_t end_bank;
  dcache_pkg::ben_t      begin_ben;
  dcache_pkg::ben_t      end_ben;
  logic [NUM_BANKS*dcache_pkg::BANK_WIDTH-1:0] data;   // bank 0 in the low word

  modport src (
    output rd, wr, set, bank_en,
    output begin_bank, end_bank, begin_ben, end_ben,
    output data
  );

  modport dst (
    input rd, wr, set, bank_en,
    input begin_bank, end_bank, begin_ben, end_ben,
    input data
  );

endinterface

`default_nettype wire

// ==== dcache_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_ram (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   addr_en,
  input  dcache_pkg::set_idx_t   addr,
  input  dcache_pkg::set_idx_t   waddr,
  input  dcache_pkg::bank_word_t wdata,
  input  logic                   wen,
  output dcache_pkg::bank_word_t rdata
);

  dcache_pkg::bank_word_t mem [dcache_pkg::SET_COUNT];
  dcache_pkg::set_idx_t   addr_q;

  // read straight off the address register so a landed write shows at once
  assign rdata = mem[addr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
    end else if (addr_en) begin
      addr_q <= addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_ram_box.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_ram_box (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd,
  input  logic                   wr,
  input  dcache_pkg::set_idx_t   set,
  input  dcache_pkg::ben_t       ben,
  input  dcache_pkg::bank_word_t wdata,
  output dcache_pkg::bank_word_t rdata
);

  dcache_pkg::set_idx_t   waddr_q;
  dcache_pkg::bank_word_t wdata_q;
  dcache_pkg::ben_t       ben_q;
  logic                   wr_q;
  dcache_pkg::bank_word_t old_word;
  dcache_pkg::bank_word_t merged;

  dcache_ram ram0 (
    .clk     (clk),
    .rst     (rst),
    .addr_en (rd | wr),     // both reads and writes need the old word
    .addr    (set),
    .waddr   (waddr_q),
    .wdata   (merged),
    .wen     (wr_q),
    .rdata   (old_word)
  );

  // byte merge of new data over the word read back
  always_comb begin
    for (int i = 0; i < dcache_pkg::BEN_WIDTH; i++) begin
      merged[8*i +: 8] = ben_q[i] ? wdata_q[8*i +: 8] : old_word[8*i +: 8];
    end
  end

  assign rdata = old_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= wr;
    end
  end

  always_ff @(posedge clk) begin
    waddr_q <= set;
    wdata_q <= wdata;
    ben_q   <= ben;
  end

endmodule

`default_nettype wire

// ==== dcache_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_bank #(
  parameter int BANK_INDEX = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  dcache_wr_if.dst               breq,
  input  dcache_pkg::bank_word_t word_in,
  output dcache_pkg::bank_word_t word_out
);

  localparam dcache_pkg::bank_idx_t MY_IDX = dcache_pkg::bank_idx_t'(BANK_INDEX);

  logic                   bank_sel;
  logic                   bank_wr;
  dcache_pkg::ben_t       ben;
  dcache_pkg::bank_word_t ram_word;
  logic                   rd_q;

  assign bank_sel = breq.bank_en[BANK_INDEX];
  assign bank_wr  = breq.wr & bank_sel;

  // begin bank takes priority when begin and end name the same bank
  always_comb begin
    if (!bank_sel) begin
      ben = '0;
    end else if (breq.begin_bank == MY_IDX) begin
      ben = breq.begin_ben;
    end else if (breq.end_bank == MY_IDX) begin
      ben = breq.end_ben;
    end else begin
      ben = dcache_pkg::BEN_ALL;   // interior bank of the store
    end
  end

  dcache_ram_box box0 (
    .clk   (clk),
    .rst   (rst),
    .rd    (breq.rd),
    .wr    (bank_wr),
    .set   (breq.set),
    .ben   (ben),
    .wdata (breq.data[BANK_INDEX*dcache_pkg::BANK_WIDTH +: dcache_pkg::BANK_WIDTH]),
    .rdata (ram_word)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= breq.rd;
    end
  end

  // idle bank passes the wired-OR chain unchanged
  assign word_out = rd_q ? (ram_word | word_in) : word_in;

endmodule

`default_nettype wire

// ==== dcache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_way #(
  parameter int NUM_BANKS = 8
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      hit,
  dcache_wr_if.dst                                  req,
  input  logic [NUM_BANKS*dcache_pkg::BANK_WIDTH-1:0] chain_in,
  output logic [NUM_BANKS*dcache_pkg::BANK_WIDTH-1:0] chain_out
);

  localparam int BW = dcache_pkg::BANK_WIDTH;

  dcache_wr_if #(.NUM_BANKS(NUM_BANKS)) breq ();

  // strobes qualified by this way's hit
  always_ff @(posedge clk) begin
    if (rst) begin
      breq.rd <= 1'b0;
      breq.wr <= 1'b0;
    end else begin
      breq.rd <= req.rd & hit;
      breq.wr <= req.wr & hit;
    end
  end

  always_ff @(posedge clk) begin
    if (req.rd | req.wr) begin
      breq.set        <= req.set;
      breq.bank_en    <= req.bank_en;
      breq.begin_bank <= req.begin_bank;
      breq.end_bank   <= req.end_bank;
      breq.begin_ben  <= req.begin_ben;
      breq.end_ben    <= req.end_ben;
      breq.data       <= req.data;
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    dcache_bank #(
      .BANK_INDEX (b)
    ) bank0 (
      .clk      (clk),
      .rst      (rst),
      .breq     (breq),
      .word_in  (chain_in[b*BW +: BW]),
      .word_out (chain_out[b*BW +: BW])
    );
  end

endmodule

`default_nettype wire

// ==== dcache_block.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_block #(
  parameter int NUM_WAYS  = 4,
  parameter int NUM_BANKS = 8
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        read_en,
  input  logic                                        write_en,
  input  logic [NUM_WAYS-1:0]                         hit_way,
  input  dcache_pkg::set_idx_t                        set,
  input  logic [NUM_BANKS-1:0]                        bank_en,
  input  dcache_pkg::bank_idx_t                       begin_bank,
  input  dcache_pkg::bank_idx_t                       end_bank,
  input  dcache_pkg::ben_t                            begin_ben,
  input  dcache_pkg::ben_t                            end_ben,
  input  logic [NUM_BANKS*dcache_pkg::BANK_WIDTH-1:0] write_data,
  output logic [NUM_BANKS*dcache_pkg::BANK_WIDTH-1:0] read_data,
  output logic                                        read_hit,
  output logic                                        read_valid
);

  localparam int LINE_W = NUM_BANKS * dcache_pkg::BANK_WIDTH;

  logic [LINE_W-1:0] chain [NUM_WAYS+1];
  logic              rd_q1;
  logic              rd_q2;
  logic              hit_q1;
  logic              hit_q2;

  dcache_wr_if #(.NUM_BANKS(NUM_BANKS)) req ();

  assign req.rd         = read_en;
  assign req.wr         = write_en;
  assign req.set        = set;
  assign req.bank_en    = bank_en;
  assign req.begin_bank = begin_bank;
  assign req.end_bank   = end_bank;
  assign req.begin_ben  = begin_ben;
  assign req.end_ben    = end_ben;
  assign req.data       = write_data;

  assign chain[0] = '0;   // missing ways add nothing to the OR

  for (genvar k = 0; k < NUM_WAYS; k++) begin : g_way
    dcache_way #(
      .NUM_BANKS (NUM_BANKS)
    ) way0 (
      .clk       (clk),
      .rst       (rst),
      .hit       (hit_way[k]),
      .req       (req),
      .chain_in  (chain[k]),
      .chain_out (chain[k+1])
    );
  end

  // read strobe and hit follow the data through the ways
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q1      <= 1'b0;
      rd_q2      <= 1'b0;
      hit_q1     <= 1'b0;
      hit_q2     <= 1'b0;
      read_valid <= 1'b0;
      read_hit   <= 1'b0;
    end else begin
      rd_q1      <= read_en;
      rd_q2      <= rd_q1;
      hit_q1     <= |hit_way;
      hit_q2     <= hit_q1;
      read_valid <= rd_q2;
      read_hit   <= rd_q2 & hit_q2;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_q2) begin
      read_data <= chain[NUM_WAYS];
    end
  end

endmodule

`default_nettype wire

// ==== dcache_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_checker #(
  parameter int NUM_WAYS = 4
) (
  input logic                clk,
  input logic                rst,
  input logic                read_en,
  input logic                write_en,
  input logic [NUM_WAYS-1:0] hit_way,
  input logic                read_valid
);

  rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(read_en && write_en))
    else $error("read_en and write_en high in the same cycle");

  hit_way_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(hit_way))
    else $error("hit_way has more than one bit set");

  // sample edge plus two pipeline stages
  read_valid_timing: assert property (@(posedge clk) disable iff (rst)
    read_valid == $past(read_en, 3))
    else $error("read_valid does not follow read_en by three edges");

endmodule

bind dcache_block dcache_checker #(
  .NUM_WAYS (NUM_WAYS)
) chk0 (
  .clk        (clk),
  .rst        (rst),
  .read_en    (read_en),
  .write_en   (write_en),
  .hit_way    (hit_way),
  .read_valid (read_valid)
);

`default_nettype wire

// ==== dcache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

  localparam int NUM_WAYS  = 4;
  localparam int NUM_BANKS = 8;
  localparam int LINE_W    = NUM_BANKS * 32;
  localparam int MAX_ROWS  = 20;
  localparam int OP_WR     = 0;
  localparam int OP_RD     = 1;
  localparam int LATENCY   = 3;
  localparam int DRAIN_MAX = 20;

  logic                  clk;
  logic                  rst;
  logic                  read_en;
  logic                  write_en;
  logic [NUM_WAYS-1:0]   hit_way;
  dcache_pkg::set_idx_t  set;
  logic [NUM_BANKS-1:0]  bank_en;
  dcache_pkg::bank_idx_t begin_bank;
  dcache_pkg::bank_idx_t end_bank;
  dcache_pkg::ben_t      begin_ben;
  dcache_pkg::ben_t      end_ben;
  logic [LINE_W-1:0]     write_data;
  logic [LINE_W-1:0]     read_data;
  logic                  read_hit;
  logic                  read_valid;

  // stimulus table
  string                t_name    [MAX_ROWS];
  int                   t_op      [MAX_ROWS];
  logic [NUM_WAYS-1:0]  t_hit     [MAX_ROWS];
  logic [7:0]           t_set     [MAX_ROWS];
  logic [NUM_BANKS-1:0] t_bank_en [MAX_ROWS];
  logic [4:0]           t_bbank   [MAX_ROWS];
  logic [4:0]           t_ebank   [MAX_ROWS];
  logic [3:0]           t_bben    [MAX_ROWS];
  logic [3:0]           t_eben    [MAX_ROWS];
  logic [LINE_W-1:0]    t_data    [MAX_ROWS];
  logic                 t_exp_hit [MAX_ROWS];
  int                   n_rows;

  logic [31:0] model [NUM_WAYS][256][NUM_BANKS];   // reference contents

  // reads in flight with the oldest first
  int                q_row   [$];
  int                q_issue [$];
  logic [LINE_W-1:0] q_data  [$];

  integer     seed;
  int         cycle;
  int         pass_cnt;
  int         err_cnt;
  int         wait_cnt;
  logic       idle_ok;
  logic [1:0] idle_seen;

  dcache_block #(
    .NUM_WAYS  (NUM_WAYS),
    .NUM_BANKS (NUM_BANKS)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .write_en   (write_en),
    .hit_way    (hit_way),
    .set        (set),
    .bank_en    (bank_en),
    .begin_bank (begin_bank),
    .end_bank   (end_bank),
    .begin_ben  (begin_ben),
    .end_ben    (end_ben),
    .write_data (write_data),
    .read_data  (read_data),
    .read_hit   (read_hit),
    .read_valid (read_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_row(input string name, input int op, input logic [3:0] hit,
                         input logic [7:0] s, input logic [7:0] ben_mask,
                         input logic [4:0] bb, input logic [4:0] eb,
                         input logic [3:0] bben, input logic [3:0] eben,
                         input logic exp_hit);
    t_name[n_rows]    = name;
    t_op[n_rows]      = op;
    t_hit[n_rows]     = hit;
    t_set[n_rows]     = s;
    t_bank_en[n_rows] = ben_mask;
    t_bbank[n_rows]   = bb;
    t_ebank[n_rows]   = eb;
    t_bben[n_rows]    = bben;
    t_eben[n_rows]    = eben;
    t_exp_hit[n_rows] = exp_hit;
    for (int b = 0; b < NUM_BANKS; b++) begin
      t_data[n_rows][32*b +: 32] = $random(seed);
    end
    n_rows++;
  endtask

  // byte enables one bank gets from a write row
  function automatic logic [3:0] bank_bytes(int r, int b);
    if (!t_bank_en[r][b]) return 4'b0000;
    if (int'(t_bbank[r]) == b) return t_bben[r];
    if (int'(t_ebank[r]) == b) return t_eben[r];
    return 4'b1111;
  endfunction

  task automatic apply_write(input int r);
    logic [3:0] m;
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        m = bank_bytes(r, b);
        for (int y = 0; y < 4; y++) begin
          if (t_hit[r][w] && m[y]) begin
            model[w][t_set[r]][b][8*y +: 8] = t_data[r][32*b + 8*y +: 8];
          end
        end
      end
    end
  endtask

  function automatic logic [LINE_W-1:0] expected_line(int r);
    logic [LINE_W-1:0] line;
    line = '0;   // no hit gives zeros
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (t_hit[r][w]) line[32*b +: 32] = line[32*b +: 32] | model[w][t_set[r]][b];
      end
    end
    return line;
  endfunction

  task automatic drive_row(input int r);
    read_en    = (t_op[r] == OP_RD);
    write_en   = (t_op[r] == OP_WR);
    hit_way    = t_hit[r];
    set        = t_set[r];
    bank_en    = t_bank_en[r];
    begin_bank = t_bbank[r];
    end_bank   = t_ebank[r];
    begin_ben  = t_bben[r];
    end_ben    = t_eben[r];
    write_data = t_data[r];
    if (t_op[r] == OP_RD) begin
      q_row.push_back(r);
      q_issue.push_back(cycle);
      q_data.push_back(expected_line(r));
    end else begin
      apply_write(r);
      $display("applied %s", t_name[r]);
    end
  endtask

  task automatic check_output();
    int                r;
    int                issue;
    logic [LINE_W-1:0] exp;
    logic              ok;
    if (read_valid === 1'b1) begin
      if (q_row.size() == 0) begin
        $display("read_valid went high with no read outstanding");
        err_cnt++;
      end else begin
        r     = q_row.pop_front();
        issue = q_issue.pop_front();
        exp   = q_data.pop_front();
        ok    = 1'b1;
        if (read_data !== exp) begin
          $display("** Error test %s: read_data expected %h, actual %h", t_name[r], exp,
                   read_data);
          ok = 1'b0;
        end
        if (read_hit !== t_exp_hit[r]) begin
          $display("** Error test %s: read_hit expected %b, actual %b", t_name[r],
                   t_exp_hit[r], read_hit);
          ok = 1'b0;
        end
        if (cycle - issue != LATENCY) begin
          $display("** Error test %s: latency expected %0d, actual %0d", t_name[r], LATENCY,
                   cycle - issue);
          ok = 1'b0;
        end
        if (ok) begin
          pass_cnt++;
          $display("ok %s", t_name[r]);
        end else begin
          err_cnt++;
        end
      end
    end else if (q_row.size() > 0 && cycle - q_issue[0] >= LATENCY) begin
      $display("test %s: read_valid did not arrive in time", t_name[q_row[0]]);
      err_cnt++;
      r     = q_row.pop_front();
      issue = q_issue.pop_front();
      exp   = q_data.pop_front();
    end
  endtask

  task automatic drive_idle();
    read_en  = 1'b0;
    write_en = 1'b0;
    hit_way  = '0;
  endtask

  task automatic build_table();
    add_row("fill_w0_s5", OP_WR, 4'b0001, 8'd5, 8'hff, 5'd0, 5'd7, 4'hf, 4'hf, 1'b0);
    add_row("fill_w1_s5", OP_WR, 4'b0010, 8'd5, 8'hff, 5'd0, 5'd7, 4'hf, 4'hf, 1'b0);
    add_row("fill_w2_s9", OP_WR, 4'b0100, 8'd9, 8'hff, 5'd0, 5'd7, 4'hf, 4'hf, 1'b0);
    add_row("fill_w3_s200", OP_WR, 4'b1000, 8'd200, 8'hff, 5'd0, 5'd7, 4'hf, 4'hf, 1'b0);
    add_row("rd_full_w0", OP_RD, 4'b0001, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("partial_w0", OP_WR, 4'b0001, 8'd5, 8'h3e, 5'd1, 5'd5, 4'hc, 4'h3, 1'b0);
    add_row("rd_partial_w0", OP_RD, 4'b0001, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("rd_other_w1", OP_RD, 4'b0010, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("rd_miss_s5", OP_RD, 4'b0000, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b0);
    add_row("same_bank_w1", OP_WR, 4'b0010, 8'd5, 8'h84, 5'd2, 5'd2, 4'h5, 4'ha, 1'b0);
    add_row("rd_same_bank_w1", OP_RD, 4'b0010, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("rd_w2_s9", OP_RD, 4'b0100, 8'd9, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("rd_w0_again", OP_RD, 4'b0001, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("no_bank_w0", OP_WR, 4'b0001, 8'd5, 8'h00, 5'd0, 5'd7, 4'hf, 4'hf, 1'b0);
    add_row("rd_no_bank_w0", OP_RD, 4'b0001, 8'd5, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("gap_w3", OP_WR, 4'b1000, 8'd200, 8'ha5, 5'd0, 5'd7, 4'h6, 4'h9, 1'b0);
    add_row("rd_gap_w3", OP_RD, 4'b1000, 8'd200, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b1);
    add_row("rd_miss_s200", OP_RD, 4'b0000, 8'd200, 8'h00, 5'd0, 5'd0, 4'h0, 4'h0, 1'b0);
  endtask

  initial begin
    seed       = 32'h83b5;
    cycle      = 0;
    pass_cnt   = 0;
    err_cnt    = 0;
    n_rows     = 0;
    rst        = 1'b1;
    read_en    = 1'b0;
    write_en   = 1'b0;
    hit_way    = '0;
    set        = '0;
    bank_en    = '0;
    begin_bank = '0;
    end_bank   = '0;
    begin_ben  = '0;
    end_ben    = '0;
    write_data = '0;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // outputs quiet after reset
    idle_ok   = 1'b1;
    idle_seen = 2'b00;
    repeat (4) begin
      @(negedge clk);
      if (read_valid !== 1'b0 || read_hit !== 1'b0) begin
        idle_ok   = 1'b0;
        idle_seen = {read_valid, read_hit};
      end
    end
    if (idle_ok) begin
      pass_cnt++;
      $display("ok reset_idle");
    end else begin
      err_cnt++;
      $display("** Error test reset_idle: read_valid/read_hit expected 0/0, actual %b/%b",
               idle_seen[1], idle_seen[0]);
    end

    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk);
      cycle++;
      check_output();
      drive_row(i);
    end
    @(negedge clk);
    cycle++;
    check_output();
    drive_idle();

    wait_cnt = 0;
    while (q_row.size() > 0 && wait_cnt < DRAIN_MAX) begin
      @(negedge clk);
      cycle++;
      check_output();
      wait_cnt++;
    end
    if (q_row.size() > 0) begin
      $display("timeout: %0d reads never returned read_valid", q_row.size());
      err_cnt++;
    end

    $display("tests: %0d passed, %0d failed", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
dcache_pkg.sv
dcache_wr_if.sv
dcache_ram.sv
dcache_ram_box.sv
dcache_bank.sv
dcache_way.sv
dcache_block.sv
dcache_checker.sv
dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run, a missing pass line counts as failure
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module dcache_tb \
  -o dcache_sim > run.log 2>&1 &&
  ./obj_dir/dcache_sim >> run.log 2>&1
grep -q "Verification failed" run.log && { echo "simulation FAILED"; exit 1; }
grep -q "Verification passed" run.log || { echo "simulation did not complete"; exit 1; }
echo "simulation PASSED"
